//--- Bender.yml
package:
  name: roce_cmd_bridge

sources:
  - hdl/roce_pkg.sv
  - hdl/sq_encoder.sv
  - hdl/flow_credit_queue.sv
  - hdl/ack_decoder.sv
  - hdl/roce_cmd_bridge.sv
  - target: test
    files:
      - dv/tb_roce_cmd_bridge.sv

//--- all.f
hdl/roce_pkg.sv
hdl/sq_encoder.sv
hdl/flow_credit_queue.sv
hdl/ack_decoder.sv
hdl/roce_cmd_bridge.sv
dv/tb_roce_cmd_bridge.sv

//--- dv/tb_roce_cmd_bridge.sv
// Testbench for the RoCE command bridge with reference queues for send words,
// acks and credit, checked by concurrent assertions
`timescale 1ns/1ps

module tb_roce_cmd_bridge
  import roce_pkg::*;
();

  localparam logic [31:0] SEED = 32'hcd50a2b7;
  localparam int TIMEOUT_CYCLES = 200;
  // Encoder register plus FIFO entries
  localparam int HOLD_SLOTS = 1 + QUEUE_DEPTH;

  logic clk = 1'b0;
  logic rst_n;
  sq_req_t s_req;
  logic s_req_valid;
  logic s_req_ready;
  logic [SQ_WORD_BITS-1:0] sq_word;
  logic sq_valid;
  logic sq_ready;
  logic [ACK_WORD_BITS-1:0] ack_word;
  logic ack_in_valid;
  logic ack_in_ready;
  ack_t m_ack;
  logic m_ack_valid;
  logic m_ack_ready;

  // Reference model state
  logic [SQ_WORD_BITS-1:0] sq_exp_q [$];
  logic [SQ_WORD_BITS-1:0] sq_head;
  ack_t ack_exp_q [$];
  ack_t ack_head;
  int sq_cnt;
  int ack_cnt;
  int credits;
  int req_in_cnt;
  int sq_out_cnt;
  int ack_in_cnt;
  int ack_out_cnt;
  int mismatches;
  int errors;
  string test_name;
  logic [31:0] rng_state;
  logic [31:0] bp_state;
  logic rand_bp;

  always #5 clk = ~clk;

  roce_cmd_bridge roce_cmd_bridge_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_req        (s_req),
    .s_req_valid  (s_req_valid),
    .s_req_ready  (s_req_ready),
    .sq_word      (sq_word),
    .sq_valid     (sq_valid),
    .sq_ready     (sq_ready),
    .ack_word     (ack_word),
    .ack_in_valid (ack_in_valid),
    .ack_in_ready (ack_in_ready),
    .m_ack        (m_ack),
    .m_ack_valid  (m_ack_valid),
    .m_ack_ready  (m_ack_ready)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Send word built field by field, bottom field last
  function automatic logic [SQ_WORD_BITS-1:0] pack_sq(input sq_req_t r);
    return {r.remote_offs, r.remote_len, r.len, r.remote_vaddr, r.local_vaddr,
            r.local_offs, r.last, r.host, r.qpn,
            {(OPCODE_FIELD_BITS-OPCODE_BITS){1'b0}}, r.opcode};
  endfunction

  // Ack word split top down; padding bits are dropped
  function automatic ack_t slice_ack(input logic [ACK_WORD_BITS-1:0] w);
    ack_t a;
    logic [OPCODE_FIELD_BITS-OPCODE_BITS-1:0] slot_pad;
    logic [QPN_BITS-PID_BITS-DEST_BITS-1:0] qpn_pad;
    logic [OPCODE_BITS-1:0] opc;
    {a.last, a.strm, a.dest, a.host, qpn_pad, a.vfid, a.pid, slot_pad, opc} = w;
    a.opcode = rdma_opcode_e'(opc);
    a.remote = 1'b1;
    return a;
  endfunction

  function automatic sq_req_t random_req();
    sq_req_t r;
    logic [63:0] r0;
    logic [63:0] r1;
    logic [63:0] r2;
    logic [63:0] r3;
    r0 = {rand32(), rand32()};
    r1 = {rand32(), rand32()};
    r2 = {rand32(), rand32()};
    r3 = {rand32(), rand32()};
    case (r3[33:32])
      2'd0:    r.opcode = RC_SEND_ONLY;
      2'd1:    r.opcode = RC_WRITE_ONLY;
      default: r.opcode = RC_READ_REQUEST;
    endcase
    r.qpn          = r0[0+:QPN_BITS];
    r.host         = r0[24];
    r.last         = r0[25];
    r.local_offs   = r0[26+:OFFS_BITS];
    r.len          = r0[30+:LEN_BITS];
    r.remote_offs  = r0[58+:OFFS_BITS];
    r.local_vaddr  = r1[0+:VADDR_BITS];
    r.remote_vaddr = r2[0+:VADDR_BITS];
    r.remote_len   = r3[0+:LEN_BITS];
    return r;
  endfunction

  // Random ack word, padding bits random too, last on top
  function automatic logic [ACK_WORD_BITS-1:0] random_ack(input logic last);
    logic [ACK_WORD_BITS-1:0] w;
    w = {rand32(), rand32()};
    w[0+:OPCODE_BITS] = RC_ACK;
    w[ACK_WORD_BITS-1] = last;
    return w;
  endfunction

  // Reference model; pops before pushes on a shared edge
  always @(posedge clk) begin
    if (!rst_n) begin
      sq_exp_q.delete();
      ack_exp_q.delete();
      credits = MAX_OUTSTANDING;
    end else begin
      if (sq_valid && sq_ready) begin
        if (sq_exp_q.size() > 0) void'(sq_exp_q.pop_front());
        sq_out_cnt++;
        credits--;
      end
      if (s_req_valid && s_req_ready) begin
        sq_exp_q.push_back(pack_sq(s_req));
        req_in_cnt++;
      end
      if (m_ack_valid && m_ack_ready) begin
        if (ack_exp_q.size() > 0) void'(ack_exp_q.pop_front());
        ack_out_cnt++;
        // Only a last ack frees a credit
        if (m_ack.last) credits++;
      end
      if (ack_in_valid && ack_in_ready) begin
        ack_exp_q.push_back(slice_ack(ack_word));
        ack_in_cnt++;
      end
    end
    sq_cnt   = sq_exp_q.size();
    ack_cnt  = ack_exp_q.size();
    sq_head  = (sq_cnt > 0) ? sq_exp_q[0] : '0;
    ack_head = (ack_cnt > 0) ? ack_exp_q[0] : '0;
  end

  // Random stalls on both output streams
  always @(negedge clk) begin
    if (rand_bp) begin
      bp_state = xorshift(bp_state);
      sq_ready = bp_state[0] | bp_state[1];
      m_ack_ready = bp_state[2] | bp_state[3];
    end
  end

  a_reset_idle: assert property (@(posedge clk) !rst_n |=> !sq_valid && !m_ack_valid)
    else begin
      errors++;
      $display("sq_valid or m_ack_valid is high right after a reset clock");
    end

  a_sq_known: assert property (@(posedge clk) disable iff (!rst_n)
    sq_valid && sq_ready |-> sq_cnt > 0)
    else begin
      errors++;
      $display("send word issued in %s with no request pending", test_name);
    end

  a_sq_word: assert property (@(posedge clk) disable iff (!rst_n)
    sq_valid && sq_ready && sq_cnt > 0 |-> sq_word == sq_head)
    else begin
      mismatches++;
      $display("MISMATCH %s sq_word expected %h actual %h",
               test_name, $sampled(sq_head), $sampled(sq_word));
    end

  // Credit limit, also proves non-last acks free nothing
  a_credit: assert property (@(posedge clk) disable iff (!rst_n) sq_valid |-> credits > 0)
    else begin
      errors++;
      $display("sq_valid high in %s while no credit is left", test_name);
    end

  a_req_ready: assert property (@(posedge clk) disable iff (!rst_n)
    s_req_ready == (sq_cnt < HOLD_SLOTS))
    else begin
      mismatches++;
      $display("MISMATCH %s s_req_ready expected %0b actual %0b",
               test_name, $sampled(sq_cnt) < HOLD_SLOTS, $sampled(s_req_ready));
    end

  a_sq_hold: assert property (@(posedge clk) disable iff (!rst_n)
    sq_valid && !sq_ready |=> sq_valid && $stable(sq_word))
    else begin
      errors++;
      $display("send word dropped or changed while stalled in %s", test_name);
    end

  // Decoder takes a new ack while empty or draining
  a_ack_in_ready: assert property (@(posedge clk) disable iff (!rst_n)
    ack_in_ready == (ack_cnt == 0 || m_ack_ready))
    else begin
      mismatches++;
      $display("MISMATCH %s ack_in_ready expected %0b actual %0b",
               test_name, $sampled(ack_cnt) == 0 || $sampled(m_ack_ready),
               $sampled(ack_in_ready));
    end

  a_ack_known: assert property (@(posedge clk) disable iff (!rst_n)
    m_ack_valid && m_ack_ready |-> ack_cnt > 0)
    else begin
      errors++;
      $display("completion handed out in %s with no ack pending", test_name);
    end

  a_ack_fields: assert property (@(posedge clk) disable iff (!rst_n)
    m_ack_valid && m_ack_ready && ack_cnt > 0 |-> m_ack == ack_head)
    else begin
      mismatches++;
      $display("MISMATCH %s m_ack expected %h actual %h",
               test_name, $sampled(ack_head), $sampled(m_ack));
    end

  a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_ack_valid && !m_ack_ready |=> m_ack_valid && $stable(m_ack))
    else begin
      errors++;
      $display("completion dropped or changed while stalled in %s", test_name);
    end

  // Holds valid until the model sees the transfer
  task automatic send_req(input sq_req_t req);
    int start;
    int waited;
    start = req_in_cnt;
    waited = 0;
    s_req = req;
    s_req_valid = 1'b1;
    while (req_in_cnt == start && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    s_req_valid = 1'b0;
    if (req_in_cnt == start) begin
      errors++;
      $display("timeout in %s: request was never accepted", test_name);
    end
  endtask

  task automatic send_ack(input logic [ACK_WORD_BITS-1:0] w);
    int start;
    int waited;
    start = ack_in_cnt;
    waited = 0;
    ack_word = w;
    ack_in_valid = 1'b1;
    while (ack_in_cnt == start && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    ack_in_valid = 1'b0;
    if (ack_in_cnt == start) begin
      errors++;
      $display("timeout in %s: ack word was never accepted", test_name);
    end
  endtask

  task automatic wait_sq_out(input int target);
    int waited;
    waited = 0;
    while (sq_out_cnt < target && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (sq_out_cnt < target) begin
      errors++;
      $display("timeout in %s: %0d of %0d send words issued", test_name, sq_out_cnt, target);
    end
  endtask

  task automatic wait_ack_out(input int target);
    int waited;
    waited = 0;
    while (ack_out_cnt < target && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (ack_out_cnt < target) begin
      errors++;
      $display("timeout in %s: %0d of %0d completions out", test_name, ack_out_cnt, target);
    end
  endtask

  initial begin
    int waited;
    rst_n = 1'b0;
    s_req = '0;
    s_req_valid = 1'b0;
    sq_ready = 1'b0;
    ack_word = '0;
    ack_in_valid = 1'b0;
    m_ack_ready = 1'b0;
    rand_bp = 1'b0;
    rng_state = SEED;
    bp_state = xorshift(SEED);
    req_in_cnt = 0;
    sq_out_cnt = 0;
    ack_in_cnt = 0;
    ack_out_cnt = 0;
    mismatches = 0;
    errors = 0;
    test_name = "reset";
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // No acks yet, so only MAX_OUTSTANDING words may leave
    test_name = "credit_limit";
    sq_ready = 1'b1;
    m_ack_ready = 1'b1;
    repeat (MAX_OUTSTANDING + 2) send_req(random_req());
    wait_sq_out(MAX_OUTSTANDING);
    repeat (20) @(negedge clk);
    assert (sq_out_cnt == MAX_OUTSTANDING)
      else begin
        mismatches++;
        $display("MISMATCH %s issued expected %0d actual %0d",
                 test_name, MAX_OUTSTANDING, sq_out_cnt);
      end

    test_name = "non_last_ack";
    repeat (3) send_ack(random_ack(1'b0));
    wait_ack_out(3);
    repeat (10) @(negedge clk);

    // One last ack, one more command
    test_name = "credit_return";
    send_ack(random_ack(1'b1));
    wait_sq_out(MAX_OUTSTANDING + 1);
    send_ack(random_ack(1'b1));
    wait_sq_out(MAX_OUTSTANDING + 2);
    repeat (MAX_OUTSTANDING) send_ack(random_ack(1'b1));
    wait_ack_out(MAX_OUTSTANDING + 5);

    // Both outputs stalled, encoder and FIFO fill up
    test_name = "backpressure";
    sq_ready = 1'b0;
    m_ack_ready = 1'b0;
    repeat (HOLD_SLOTS) send_req(random_req());
    s_req = random_req();
    s_req_valid = 1'b1;
    send_ack(random_ack(1'b0));
    repeat (10) @(negedge clk);
    assert (req_in_cnt == MAX_OUTSTANDING + 2 + HOLD_SLOTS)
      else begin
        mismatches++;
        $display("MISMATCH %s accepted expected %0d actual %0d",
                 test_name, MAX_OUTSTANDING + 2 + HOLD_SLOTS, req_in_cnt);
      end
    rand_bp = 1'b1;
    waited = 0;
    while (req_in_cnt <= MAX_OUTSTANDING + 2 + HOLD_SLOTS && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    s_req_valid = 1'b0;
    if (req_in_cnt <= MAX_OUTSTANDING + 2 + HOLD_SLOTS) begin
      errors++;
      $display("timeout in %s: held request was never accepted", test_name);
    end
    wait_sq_out(2 * MAX_OUTSTANDING + 2);
    repeat (MAX_OUTSTANDING) send_ack(random_ack(1'b1));
    wait_ack_out(2 * MAX_OUTSTANDING + 6);

    // Random stalls, acks return credit pair by pair
    test_name = "random_traffic";
    for (int i = 0; i < 4; i++) begin
      send_req(random_req());
      send_req(random_req());
      wait_sq_out(2 * MAX_OUTSTANDING + 4 + 2 * i);
      send_ack(random_ack(1'b1));
      send_ack(random_ack(1'b1));
      wait_ack_out(2 * MAX_OUTSTANDING + 8 + 2 * i);
    end
    rand_bp = 1'b0;
    repeat (5) @(negedge clk);

    $display("report: %0d requests, %0d send words, %0d acks, %0d mismatches, %0d errors",
             req_in_cnt, sq_out_cnt, ack_out_cnt, mismatches, errors);
    if (mismatches == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/ack_decoder.sv
// Acknowledge decoder that registers the flat stack word, unpacks it into
// a completion and flags credit return on last
`timescale 1ns/1ps

module ack_decoder
  import roce_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,

  // Flat acknowledge from the stack
  input  logic [ACK_WORD_BITS-1:0] ack_word,
  input  logic                     ack_in_valid,
  output logic                     ack_in_ready,

  // Decoded completion to the user
  output ack_t                     m_ack,
  output logic                     m_ack_valid,
  input  logic                     m_ack_ready,

  // Towards the flow control
  output logic                     credit_return
);

  // Held flat word and occupancy
  logic [ACK_WORD_BITS-1:0] ack_q;
  logic                     full_q;
  logic                     ack_accept;
  logic                     ack_out;

  // Stall only while full and not draining
  assign ack_in_ready = !full_q || m_ack_ready;
  assign ack_accept   = ack_in_valid && ack_in_ready;
  assign m_ack_valid  = full_q;
  assign ack_out      = m_ack_valid && m_ack_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (ack_accept) begin
      full_q <= 1'b1;
    end else if (m_ack_ready) begin
      full_q <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (ack_accept) begin
      ack_q <= ack_word;
    end
  end

  // Unpack fields
  assign m_ack.opcode = rdma_opcode_e'(ack_q[0+:OPCODE_BITS]);
  // Completions here always come from the remote side
  assign m_ack.remote = 1'b1;
  // pid and vfid live in the qpn slot
  assign m_ack.pid    = ack_q[ACK_PID_OFFS+:PID_BITS];
  assign m_ack.vfid   = ack_q[ACK_VFID_OFFS+:DEST_BITS];
  assign m_ack.host   = ack_q[ACK_HOST_OFFS];
  assign m_ack.dest   = ack_q[ACK_DEST_OFFS+:DEST_BITS];
  assign m_ack.strm   = ack_q[ACK_STRM_OFFS+:STRM_BITS];
  assign m_ack.last   = ack_q[ACK_LAST_OFFS];

  // Only the final ack of a command frees its credit
  assign credit_return = ack_out && m_ack.last;

  // Held completion stays put under backpressure
  a_ack_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    m_ack_valid && !m_ack_ready |=> m_ack_valid && $stable(m_ack)
  );

endmodule

//--- hdl/flow_credit_queue.sv
// Outstanding-command FIFO with credit-gated issue to the stack
`timescale 1ns/1ps

module flow_credit_queue
  import roce_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,

  // Packed commands from the encoder
  input  logic [SQ_WORD_BITS-1:0] enc_word,
  input  logic                    enc_valid,
  output logic                    enc_ready,

  // Send queue towards the stack
  output logic [SQ_WORD_BITS-1:0] sq_word,
  output logic                    sq_valid,
  input  logic                    sq_ready,

  // One pulse per completed command
  input  logic                    credit_return
);

  // FIFO storage
  logic [SQ_WORD_BITS-1:0] fifo_mem [QUEUE_DEPTH];
  logic [PTR_BITS-1:0]     wr_ptr_q;
  logic [PTR_BITS-1:0]     rd_ptr_q;
  logic [CNT_BITS-1:0]     count_q;

  // Credits left for in-flight commands
  logic [CREDIT_BITS-1:0]  credit_q;

  logic wr_en;
  logic rd_en;
  logic fifo_empty;
  logic fifo_full;

  assign fifo_empty = (count_q == '0);
  assign fifo_full  = (count_q == CNT_BITS'(QUEUE_DEPTH));

  // Backpressure to the encoder on full
  assign enc_ready = !fifo_full;
  assign wr_en     = enc_valid && enc_ready;

  // Head of queue goes out only while credit remains
  assign sq_valid = !fifo_empty && (credit_q != '0);
  assign sq_word  = fifo_mem[rd_ptr_q];
  assign rd_en    = sq_valid && sq_ready;

  // Write side
  always_ff @(posedge clk) begin
    if (wr_en) begin
      fifo_mem[wr_ptr_q] <= enc_word;
    end
  end

  // Pointers, wrap at depth
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Credit spent on issue, regained on return; both may hit together
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_q <= CREDIT_BITS'(MAX_OUTSTANDING);
    end else begin
      case ({rd_en, credit_return})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Returns never outnumber issued commands
  a_credit_max: assert property (
    @(posedge clk) disable iff (!rst_n)
    credit_q <= CREDIT_BITS'(MAX_OUTSTANDING)
  );

endmodule

//--- hdl/roce_cmd_bridge.sv
// Top level of the RoCE command bridge with encoder, credit queue
// and ack decoder
`timescale 1ns/1ps

module roce_cmd_bridge
  import roce_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,

  // User send queue
  input  sq_req_t                  s_req,
  input  logic                     s_req_valid,
  output logic                     s_req_ready,

  // Flat send word to the stack
  output logic [SQ_WORD_BITS-1:0]  sq_word,
  output logic                     sq_valid,
  input  logic                     sq_ready,

  // Flat ack from the stack
  input  logic [ACK_WORD_BITS-1:0] ack_word,
  input  logic                     ack_in_valid,
  output logic                     ack_in_ready,

  // Decoded completions
  output ack_t                     m_ack,
  output logic                     m_ack_valid,
  input  logic                     m_ack_ready
);

  // Encoder to queue
  logic [SQ_WORD_BITS-1:0] enc_word;
  logic                    enc_valid;
  logic                    enc_ready;

  // Decoder back to queue
  logic                    credit_return;

  sq_encoder sq_encoder_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_req       (s_req),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .enc_word    (enc_word),
    .enc_valid   (enc_valid),
    .enc_ready   (enc_ready)
  );

  // Limits commands in flight
  flow_credit_queue flow_credit_queue_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .enc_word      (enc_word),
    .enc_valid     (enc_valid),
    .enc_ready     (enc_ready),
    .sq_word       (sq_word),
    .sq_valid      (sq_valid),
    .sq_ready      (sq_ready),
    .credit_return (credit_return)
  );

  ack_decoder ack_decoder_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ack_word      (ack_word),
    .ack_in_valid  (ack_in_valid),
    .ack_in_ready  (ack_in_ready),
    .m_ack         (m_ack),
    .m_ack_valid   (m_ack_valid),
    .m_ack_ready   (m_ack_ready),
    .credit_return (credit_return)
  );

endmodule

//--- hdl/roce_pkg.sv
// Field widths, flat word offsets, RDMA opcodes and the request/ack structs
// for the RoCE command bridge
package roce_pkg;

  // Field widths
  localparam int OPCODE_BITS       = 5;
  localparam int OPCODE_FIELD_BITS = 32;
  localparam int QPN_BITS          = 24;
  localparam int VADDR_BITS        = 48;
  localparam int LEN_BITS          = 28;
  localparam int OFFS_BITS         = 4;
  localparam int PID_BITS          = 6;
  localparam int DEST_BITS         = 4;
  localparam int STRM_BITS         = 2;

  // Immediate carries remote offs above remote len
  localparam int IMM_BITS = OFFS_BITS + LEN_BITS;

  // Send word layout, upward from the opcode slot
  localparam int SQ_QPN_OFFS    = OPCODE_FIELD_BITS;
  localparam int SQ_HOST_OFFS   = SQ_QPN_OFFS + QPN_BITS;
  localparam int SQ_LAST_OFFS   = SQ_HOST_OFFS + 1;
  localparam int SQ_LOFFS_OFFS  = SQ_LAST_OFFS + 1;
  localparam int SQ_LVADDR_OFFS = SQ_LOFFS_OFFS + OFFS_BITS;
  localparam int SQ_RVADDR_OFFS = SQ_LVADDR_OFFS + VADDR_BITS;
  localparam int SQ_LEN_OFFS    = SQ_RVADDR_OFFS + VADDR_BITS;
  localparam int SQ_IMM_OFFS    = SQ_LEN_OFFS + LEN_BITS;
  localparam int SQ_WORD_BITS   = SQ_IMM_OFFS + IMM_BITS;

  // Ack word layout; pid and vfid share a QPN-wide slot
  localparam int ACK_PID_OFFS  = OPCODE_FIELD_BITS;
  localparam int ACK_VFID_OFFS = ACK_PID_OFFS + PID_BITS;
  localparam int ACK_HOST_OFFS = OPCODE_FIELD_BITS + QPN_BITS;
  localparam int ACK_DEST_OFFS = ACK_HOST_OFFS + 1;
  localparam int ACK_STRM_OFFS = ACK_DEST_OFFS + DEST_BITS;
  localparam int ACK_LAST_OFFS = ACK_STRM_OFFS + STRM_BITS;
  localparam int ACK_WORD_BITS = ACK_LAST_OFFS + 1;

  // Flow control
  localparam int MAX_OUTSTANDING = 4;
  localparam int QUEUE_DEPTH     = 2;
  localparam int CREDIT_BITS     = $clog2(MAX_OUTSTANDING + 1);
  localparam int CNT_BITS        = $clog2(QUEUE_DEPTH + 1);
  localparam int PTR_BITS        = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

  // RC opcodes used on the user side
  typedef enum logic [OPCODE_BITS-1:0] {
    RC_SEND_ONLY      = 5'h04,
    RC_WRITE_ONLY     = 5'h0a,
    RC_READ_REQUEST   = 5'h0c,
    RC_READ_RESP_ONLY = 5'h10,
    RC_ACK            = 5'h11
  } rdma_opcode_e;

  // User send-queue request
  typedef struct packed {
    rdma_opcode_e           opcode;
    logic [QPN_BITS-1:0]    qpn;
    logic                   host;
    logic                   last;
    logic [OFFS_BITS-1:0]   local_offs;
    logic [VADDR_BITS-1:0]  local_vaddr;
    logic [VADDR_BITS-1:0]  remote_vaddr;
    logic [LEN_BITS-1:0]    len;
    logic [OFFS_BITS-1:0]   remote_offs;
    logic [LEN_BITS-1:0]    remote_len;
  } sq_req_t;

  // Decoded completion
  typedef struct packed {
    rdma_opcode_e           opcode;
    logic                   remote;
    logic [PID_BITS-1:0]    pid;
    logic [DEST_BITS-1:0]   vfid;
    logic                   host;
    logic [DEST_BITS-1:0]   dest;
    logic [STRM_BITS-1:0]   strm;
    logic                   last;
  } ack_t;

endpackage

//--- hdl/sq_encoder.sv
// Send-queue encoder with one register stage that packs a user request
// into the flat stack word
`timescale 1ns/1ps

module sq_encoder
  import roce_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,

  // User request stream
  input  sq_req_t                 s_req,
  input  logic                    s_req_valid,
  output logic                    s_req_ready,

  // Packed word towards the queue
  output logic [SQ_WORD_BITS-1:0] enc_word,
  output logic                    enc_valid,
  input  logic                    enc_ready
);

  // Held request and occupancy flag
  sq_req_t req_q;
  logic    full_q;
  logic    req_accept;

  // Ready when empty or draining this cycle
  assign s_req_ready = !full_q || enc_ready;
  assign req_accept  = s_req_valid && s_req_ready;
  assign enc_valid   = full_q;

  // Occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (req_accept) begin
      full_q <= 1'b1;
    end else if (enc_ready) begin
      full_q <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (req_accept) begin
      req_q <= s_req;
    end
  end

  // Flat send word, unused bits stay zero
  always_comb begin
    enc_word = '0;
    // Opcode in the low slot
    enc_word[0+:OPCODE_BITS]             = req_q.opcode;
    enc_word[SQ_QPN_OFFS+:QPN_BITS]      = req_q.qpn;
    enc_word[SQ_HOST_OFFS]               = req_q.host;
    enc_word[SQ_LAST_OFFS]               = req_q.last;
    // Local side of the transfer
    enc_word[SQ_LOFFS_OFFS+:OFFS_BITS]   = req_q.local_offs;
    enc_word[SQ_LVADDR_OFFS+:VADDR_BITS] = req_q.local_vaddr;
    // Remote address and length
    enc_word[SQ_RVADDR_OFFS+:VADDR_BITS] = req_q.remote_vaddr;
    enc_word[SQ_LEN_OFFS+:LEN_BITS]      = req_q.len;
    // Immediate, remote offs on top of remote len
    enc_word[SQ_IMM_OFFS+:IMM_BITS]      = {req_q.remote_offs, req_q.remote_len};
  end

  // Stalled output keeps its word and valid
  a_enc_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    enc_valid && !enc_ready |=> enc_valid && $stable(enc_word)
  );

endmodule
